// File: sources.f
hdl/l2_cache_pkg.sv
hdl/l2_cache_way.sv
hdl/l2_cache_datapath.sv
hdl/l2_cache_control.sv
hdl/l2_cache.sv
sim/l2_cache_checker.sv
sim/tb_l2_cache.sv

// File: Bender.yml
package:
  name: l2_cache

sources:
  - hdl/l2_cache_pkg.sv
  - hdl/l2_cache_way.sv
  - hdl/l2_cache_datapath.sv
  - hdl/l2_cache_control.sv
  - hdl/l2_cache.sv
  - target: simulation
    files:
      - sim/l2_cache_checker.sv
      - sim/tb_l2_cache.sv

// File: sim/tb_l2_cache.sv
`timescale 1ns/100ps

module tb_l2_cache;
    import l2_cache_pkg::*;

    localparam int   clk_period   = 100;
    localparam int   reset_cycles = 3;
    localparam int   num_rows     = 19;
    localparam logic op_read      = 1'b0;
    localparam logic op_write     = 1'b1;

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] be;
        logic [31:0] word;
        logic        miss;
        logic        wb;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic [addr_bits-1:0]  mem_address;
    logic                  mem_read;
    logic                  mem_write;
    logic [line_bytes-1:0] mem_byte_enable256;
    logic [line_bits-1:0]  mem_wdata256;
    logic [line_bits-1:0]  mem_rdata256;
    logic                  mem_resp;
    logic [addr_bits-1:0]  pmem_address;
    logic                  pmem_read;
    logic                  pmem_write;
    logic [line_bits-1:0]  pmem_wdata;
    logic [line_bits-1:0]  pmem_rdata;
    logic                  pmem_resp;
    logic                  exp_miss;
    logic                  exp_wb;
    int                    test_num;
    int                    error_count;
    int                    test_count;
    integer                seed = 52598;
    int unsigned           latency;
    logic [addr_bits-1:0]  key;
    row_t                  rows [num_rows];
    logic [line_bits-1:0]  phys_mem [logic [addr_bits-1:0]];

    function automatic row_t make_row(input logic write, input logic [31:0] addr,
                                      input logic [31:0] be, input logic [31:0] word,
                                      input logic miss, input logic wb);
        row_t r;
        r.write = write;
        r.addr  = addr;
        r.be    = be;
        r.word  = word;
        r.miss  = miss;
        r.wb    = wb;
        return r;
    endfunction

    function automatic logic [addr_bits-1:0] line_base(input logic [addr_bits-1:0] addr);
        l2_addr_t a;
        a.raw = addr;
        a.fields.offset = '0;
        return a.raw;
    endfunction

    // op, address, byte enables, data word, miss, write-back.
    task automatic load_table();
        // set 1 with tags A, B and C.
        rows[0]  = make_row(op_read,  32'h0000_0120, 32'h0, 32'h0, 1'b1, 1'b0);
        rows[1]  = make_row(op_read,  32'h0000_013c, 32'h0, 32'h0, 1'b0, 1'b0);
        rows[2]  = make_row(op_write, 32'h0000_0120, 32'h0000_000f, 32'hdead_beef, 1'b0, 1'b0);
        rows[3]  = make_row(op_read,  32'h0000_0120, 32'h0, 32'h0, 1'b0, 1'b0);
        rows[4]  = make_row(op_read,  32'h0000_0220, 32'h0, 32'h0, 1'b1, 1'b0);
        rows[5]  = make_row(op_read,  32'h0000_0120, 32'h0, 32'h0, 1'b0, 1'b0);
        rows[6]  = make_row(op_read,  32'h0000_0320, 32'h0, 32'h0, 1'b1, 1'b0);
        rows[7]  = make_row(op_read,  32'h0000_0220, 32'h0, 32'h0, 1'b1, 1'b1);
        rows[8]  = make_row(op_read,  32'h0000_0120, 32'h0, 32'h0, 1'b1, 1'b0);
        // set 2, write miss then dirty eviction.
        rows[9]  = make_row(op_write, 32'h0000_0140, 32'hf0f0_0000, 32'h1234_5678, 1'b1, 1'b0);
        rows[10] = make_row(op_read,  32'h0000_0140, 32'h0, 32'h0, 1'b0, 1'b0);
        rows[11] = make_row(op_read,  32'h0000_0240, 32'h0, 32'h0, 1'b1, 1'b0);
        rows[12] = make_row(op_read,  32'h0000_0340, 32'h0, 32'h0, 1'b1, 1'b1);
        rows[13] = make_row(op_read,  32'h0000_12a0, 32'h0, 32'h0, 1'b1, 1'b0);
        rows[14] = make_row(op_write, 32'h0000_12c0, 32'hffff_ffff, 32'hcafe_f00d, 1'b1, 1'b0);
        rows[15] = make_row(op_read,  32'h0000_12a0, 32'h0, 32'h0, 1'b0, 1'b0);
        rows[16] = make_row(op_read,  32'h0000_12c0, 32'h0, 32'h0, 1'b0, 1'b0);
        // write hit on way 1.
        rows[17] = make_row(op_write, 32'h0000_0240, 32'h00ff_00ff, 32'ha5c3_5a3c, 1'b0, 1'b0);
        rows[18] = make_row(op_read,  32'h0000_0240, 32'h0, 32'h0, 1'b0, 1'b0);
    endtask

    l2_cache u_dut (
        .clk (clk), .rst (rst),
        .mem_address (mem_address), .mem_read (mem_read), .mem_write (mem_write),
        .mem_byte_enable256 (mem_byte_enable256), .mem_wdata256 (mem_wdata256),
        .mem_rdata256 (mem_rdata256), .mem_resp (mem_resp),
        .pmem_address (pmem_address), .pmem_read (pmem_read), .pmem_write (pmem_write),
        .pmem_wdata (pmem_wdata), .pmem_rdata (pmem_rdata), .pmem_resp (pmem_resp)
    );

    l2_cache_checker u_checker (
        .clk (clk), .rst (rst),
        .mem_address (mem_address), .mem_read (mem_read), .mem_write (mem_write),
        .mem_byte_enable256 (mem_byte_enable256), .mem_wdata256 (mem_wdata256),
        .mem_rdata256 (mem_rdata256), .mem_resp (mem_resp),
        .pmem_address (pmem_address), .pmem_read (pmem_read), .pmem_write (pmem_write),
        .pmem_wdata (pmem_wdata), .pmem_resp (pmem_resp),
        .test_num (test_num), .exp_miss (exp_miss), .exp_wb (exp_wb),
        .error_count (error_count), .test_count (test_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // line memory with 1 to 4 cycles of latency
    ////////////////////////////////////////////////////////////

    initial begin
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        forever begin
            @(negedge clk);
            if (pmem_resp) begin
                pmem_resp = 1'b0;
            end else if (pmem_read || pmem_write) begin
                latency = 1 + ($unsigned($random(seed)) % 4);
                repeat (latency - 1) @(negedge clk);
                key = line_base(pmem_address);
                if (pmem_write) begin
                    phys_mem[key] = pmem_wdata;
                end else if (phys_mem.exists(key)) begin
                    pmem_rdata = phys_mem[key];
                end else begin
                    pmem_rdata = {8{key}};
                end
                pmem_resp = 1'b1;
            end
        end
    end

    initial begin
        #(clk_period * (reset_cycles + num_rows * 40));
        $display("watchdog expired before all requests were answered.");
        $display("RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        rst                = 1'b1;
        mem_address        = '0;
        mem_read           = 1'b0;
        mem_write          = 1'b0;
        mem_byte_enable256 = '0;
        mem_wdata256       = '0;
        exp_miss           = 1'b0;
        exp_wb             = 1'b0;
        test_num           = 0;
        load_table();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < num_rows; i++) begin
            test_num           = i;
            exp_miss           = rows[i].miss;
            exp_wb             = rows[i].wb;
            mem_address        = rows[i].addr;
            mem_byte_enable256 = rows[i].be;
            mem_wdata256       = {8{rows[i].word}};
            mem_read           = !rows[i].write;
            mem_write          = rows[i].write;
            @(posedge clk);
            while (!mem_resp) begin
                @(posedge clk);
            end
            @(negedge clk);
            mem_read  = 1'b0;
            mem_write = 1'b0;
        end
        @(negedge clk);
        $display("tests run %0d of %0d, errors %0d", test_count, num_rows, error_count);
        if ((error_count == 0) && (test_count == num_rows)) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_l2_cache

// File: sim/l2_cache_checker.sv
`timescale 1ns/100ps

module l2_cache_checker (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [l2_cache_pkg::addr_bits-1:0]  mem_address,
    input  logic                                mem_read,
    input  logic                                mem_write,
    input  logic [l2_cache_pkg::line_bytes-1:0] mem_byte_enable256,
    input  logic [l2_cache_pkg::line_bits-1:0]  mem_wdata256,
    input  logic [l2_cache_pkg::line_bits-1:0]  mem_rdata256,
    input  logic                                mem_resp,
    input  logic [l2_cache_pkg::addr_bits-1:0]  pmem_address,
    input  logic                                pmem_read,
    input  logic                                pmem_write,
    input  logic [l2_cache_pkg::line_bits-1:0]  pmem_wdata,
    input  logic                                pmem_resp,
    input  int                                  test_num,
    input  logic                                exp_miss,
    input  logic                                exp_wb,
    output int                                  error_count,
    output int                                  test_count
);
    import l2_cache_pkg::*;

    // architectural view of memory, written lines only.
    logic [line_bits-1:0] shadow [logic [addr_bits-1:0]];
    logic                 rst_q = 1'b1;
    int                   fills;
    int                   write_backs;
    int                   req_cycles;
    int                   errors_at_start;

    function automatic logic [addr_bits-1:0] line_base(input logic [addr_bits-1:0] addr);
        l2_addr_t a;
        a.raw = addr;
        a.fields.offset = '0;
        return a.raw;
    endfunction

    // untouched lines hold their own address in every word.
    function automatic logic [line_bits-1:0] shadow_line(input logic [addr_bits-1:0] addr);
        logic [addr_bits-1:0] key;
        key = line_base(addr);
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return {8{key}};
    endfunction

    ////////////////////////////////////////////////////////////
    // comparisons, sampled on the rising edge
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        logic [line_bits-1:0] expected;
        if (rst) begin
            error_count     = 0;
            test_count      = 0;
            fills           = 0;
            write_backs     = 0;
            req_cycles      = 0;
            errors_at_start = 0;
        end else begin
            if (rst_q && (mem_resp || pmem_read || pmem_write)) begin
                $display("[ERROR] after reset mem_resp %h pmem_read %h pmem_write %h, expected 0",
                         mem_resp, pmem_read, pmem_write);
                error_count++;
            end
            if (mem_read || mem_write) begin
                req_cycles++;
            end
            if (pmem_read && pmem_resp) begin
                fills++;
                if (pmem_address !== line_base(mem_address)) begin
                    $display("[ERROR] test %0d pmem_address got %h expected %h",
                             test_num, pmem_address, line_base(mem_address));
                    error_count++;
                end
            end
            if (pmem_write && pmem_resp) begin
                write_backs++;
                expected = shadow_line(pmem_address);
                if (pmem_wdata !== expected) begin
                    $display("[ERROR] test %0d pmem_wdata at %h got %h expected %h",
                             test_num, pmem_address, pmem_wdata, expected);
                    error_count++;
                end
            end
            if (mem_resp) begin
                expected = shadow_line(mem_address);
                if (mem_read && (mem_rdata256 !== expected)) begin
                    $display("[ERROR] test %0d mem_rdata256 got %h expected %h",
                             test_num, mem_rdata256, expected);
                    error_count++;
                end
                if (mem_write) begin
                    for (int b = 0; b < line_bytes; b++) begin
                        if (mem_byte_enable256[b]) begin
                            expected[b*8 +: 8] = mem_wdata256[b*8 +: 8];
                        end
                    end
                    shadow[line_base(mem_address)] = expected;
                end
                if (fills != int'(exp_miss)) begin
                    $display("test %0d: expected %0d line fills from memory but saw %0d.",
                             test_num, exp_miss, fills);
                    error_count++;
                end
                if (write_backs != int'(exp_wb)) begin
                    $display("test %0d: expected %0d write-backs but saw %0d.",
                             test_num, exp_wb, write_backs);
                    error_count++;
                end
                // a hit answers in the cycle after the request is first sampled.
                if (!exp_miss && (req_cycles != 2)) begin
                    $display("test %0d: hit response took %0d cycles instead of 2.",
                             test_num, req_cycles);
                    error_count++;
                end
                $display("test %0d %s %h: %s", test_num, mem_write ? "write" : "read",
                         mem_address, (error_count == errors_at_start) ? "ok" : "failed");
                test_count++;
                fills           = 0;
                write_backs     = 0;
                req_cycles      = 0;
                errors_at_start = error_count;
            end
        end
        rst_q = rst;
    end

endmodule : l2_cache_checker

// File: hdl/l2_cache.sv
`timescale 1ns/100ps

module l2_cache (
    input  logic                                clk,
    input  logic                                rst,

    input  logic [l2_cache_pkg::addr_bits-1:0]  mem_address,
    input  logic                                mem_read,
    input  logic                                mem_write,
    input  logic [l2_cache_pkg::line_bytes-1:0] mem_byte_enable256,
    input  logic [l2_cache_pkg::line_bits-1:0]  mem_wdata256,
    output logic [l2_cache_pkg::line_bits-1:0]  mem_rdata256,
    output logic                                mem_resp,

    output logic [l2_cache_pkg::addr_bits-1:0]  pmem_address,
    output logic                                pmem_read,
    output logic                                pmem_write,
    output logic [l2_cache_pkg::line_bits-1:0]  pmem_wdata,
    input  logic [l2_cache_pkg::line_bits-1:0]  pmem_rdata,
    input  logic                                pmem_resp
);
    import l2_cache_pkg::*;

    logic                  ld_tag0, ld_tag1, ld_valid0, ld_valid1;
    logic                  ld_dirty0, ld_dirty1, ld_lru;
    logic                  valid0_in, valid1_in, dirty0_in, dirty1_in, lru_in;
    logic                  datain0_sel, datain1_sel, mem_addr_sel;
    logic [line_bytes-1:0] byte_enable0;
    logic [line_bytes-1:0] byte_enable1;
    logic                  hit0, hit1, lru_out;
    logic                  valid0_out, valid1_out, dirty0_out, dirty1_out;

    l2_cache_control u_control (
        .clk (clk), .rst (rst),
        .lru_out (lru_out), .dirty0_out (dirty0_out), .dirty1_out (dirty1_out),
        .valid0_out (valid0_out), .valid1_out (valid1_out), .hit0 (hit0), .hit1 (hit1),
        .mem_byte_enable256 (mem_byte_enable256), .mem_read (mem_read),
        .mem_write (mem_write), .pmem_resp (pmem_resp),
        .ld_tag0 (ld_tag0), .ld_tag1 (ld_tag1), .ld_valid0 (ld_valid0),
        .ld_valid1 (ld_valid1), .ld_dirty0 (ld_dirty0), .ld_dirty1 (ld_dirty1),
        .ld_lru (ld_lru), .valid0_in (valid0_in), .valid1_in (valid1_in),
        .dirty0_in (dirty0_in), .dirty1_in (dirty1_in), .lru_in (lru_in),
        .datain0_sel (datain0_sel), .datain1_sel (datain1_sel),
        .mem_addr_sel (mem_addr_sel), .byte_enable0 (byte_enable0),
        .byte_enable1 (byte_enable1), .pmem_read (pmem_read),
        .pmem_write (pmem_write), .mem_resp (mem_resp)
    );

    l2_cache_datapath u_datapath (
        .clk (clk), .rst (rst),
        .mem_address (mem_address), .mem_wdata256 (mem_wdata256),
        .pmem_rdata (pmem_rdata),
        .ld_tag0 (ld_tag0), .ld_tag1 (ld_tag1), .ld_valid0 (ld_valid0),
        .ld_valid1 (ld_valid1), .ld_dirty0 (ld_dirty0), .ld_dirty1 (ld_dirty1),
        .ld_lru (ld_lru), .valid0_in (valid0_in), .valid1_in (valid1_in),
        .dirty0_in (dirty0_in), .dirty1_in (dirty1_in), .lru_in (lru_in),
        .datain0_sel (datain0_sel), .datain1_sel (datain1_sel),
        .mem_addr_sel (mem_addr_sel), .byte_enable0 (byte_enable0),
        .byte_enable1 (byte_enable1),
        .hit0 (hit0), .hit1 (hit1), .lru_out (lru_out),
        .valid0_out (valid0_out), .valid1_out (valid1_out),
        .dirty0_out (dirty0_out), .dirty1_out (dirty1_out),
        .mem_rdata256 (mem_rdata256), .pmem_address (pmem_address),
        .pmem_wdata (pmem_wdata)
    );

endmodule : l2_cache

// File: hdl/l2_cache_control.sv
`timescale 1ns/100ps

module l2_cache_control (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                lru_out,
    input  logic                                dirty0_out,
    input  logic                                dirty1_out,
    input  logic                                valid0_out,
    input  logic                                valid1_out,
    input  logic                                hit0,
    input  logic                                hit1,

    input  logic [l2_cache_pkg::line_bytes-1:0] mem_byte_enable256,
    input  logic                                mem_read,
    input  logic                                mem_write,
    input  logic                                pmem_resp,

    output logic                                ld_tag0,
    output logic                                ld_tag1,
    output logic                                ld_valid0,
    output logic                                ld_valid1,
    output logic                                ld_dirty0,
    output logic                                ld_dirty1,
    output logic                                ld_lru,
    output logic                                valid0_in,
    output logic                                valid1_in,
    output logic                                dirty0_in,
    output logic                                dirty1_in,
    output logic                                lru_in,
    output logic                                datain0_sel,
    output logic                                datain1_sel,
    output logic                                mem_addr_sel,
    output logic [l2_cache_pkg::line_bytes-1:0] byte_enable0,
    output logic [l2_cache_pkg::line_bytes-1:0] byte_enable1,
    output logic                                pmem_read,
    output logic                                pmem_write,
    output logic                                mem_resp
);

    typedef enum logic [2:0] {
        idle,
        cache_access,
        write_back,
        read,
        done
    } state_t;

    state_t state;
    state_t next_state;

    logic victim_dirty;

    // the way named by lru_out is replaced on a miss.
    assign victim_dirty = lru_out ? (valid1_out && dirty1_out)
                                  : (valid0_out && dirty0_out);

    ////////////////////////////////////////////////////////////
    // state outputs
    ////////////////////////////////////////////////////////////

    always_comb begin
        ld_tag0      = 1'b0;
        ld_tag1      = 1'b0;
        ld_valid0    = 1'b0;
        ld_valid1    = 1'b0;
        ld_dirty0    = 1'b0;
        ld_dirty1    = 1'b0;
        ld_lru       = 1'b0;
        valid0_in    = 1'b0;
        valid1_in    = 1'b0;
        dirty0_in    = 1'b0;
        dirty1_in    = 1'b0;
        lru_in       = 1'b0;
        datain0_sel  = 1'b0;
        datain1_sel  = 1'b0;
        mem_addr_sel = 1'b0;
        byte_enable0 = '0;
        byte_enable1 = '0;
        pmem_read    = 1'b0;
        pmem_write   = 1'b0;
        mem_resp     = 1'b0;

        case (state)
            // done sees the freshly filled line as a hit.
            cache_access, done: begin
                if (hit0 || hit1) begin
                    mem_resp = 1'b1;
                    ld_lru   = 1'b1;
                    lru_in   = hit0;
                end
                if (hit0 && mem_write) begin
                    ld_dirty0    = 1'b1;
                    dirty0_in    = 1'b1;
                    byte_enable0 = mem_byte_enable256;
                end else if (hit1 && mem_write) begin
                    ld_dirty1    = 1'b1;
                    dirty1_in    = 1'b1;
                    byte_enable1 = mem_byte_enable256;
                end
            end

            write_back: begin
                pmem_write   = 1'b1;
                mem_addr_sel = 1'b1;
            end

            read: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    if (lru_out) begin
                        datain1_sel  = 1'b1;
                        ld_tag1      = 1'b1;
                        ld_valid1    = 1'b1;
                        valid1_in    = 1'b1;
                        ld_dirty1    = 1'b1;
                        byte_enable1 = '1;
                    end else begin
                        datain0_sel  = 1'b1;
                        ld_tag0      = 1'b1;
                        ld_valid0    = 1'b1;
                        valid0_in    = 1'b1;
                        ld_dirty0    = 1'b1;
                        byte_enable0 = '1;
                    end
                end
            end

            default: begin
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        unique case (state)
            idle: begin
                if (mem_read || mem_write) begin
                    next_state = cache_access;
                end
            end
            cache_access: begin
                if (hit0 || hit1) begin
                    next_state = idle;
                end else if (victim_dirty) begin
                    next_state = write_back;
                end else begin
                    next_state = read;
                end
            end
            write_back: begin
                if (pmem_resp) begin
                    next_state = read;
                end
            end
            read: begin
                if (pmem_resp) begin
                    next_state = done;
                end
            end
            done: begin
                next_state = idle;
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    a_pmem_exclusive : assert property (
        @(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write)
    );

endmodule : l2_cache_control

// File: hdl/l2_cache_datapath.sv
`timescale 1ns/100ps

module l2_cache_datapath (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [l2_cache_pkg::addr_bits-1:0]  mem_address,
    input  logic [l2_cache_pkg::line_bits-1:0]  mem_wdata256,
    input  logic [l2_cache_pkg::line_bits-1:0]  pmem_rdata,

    input  logic                                ld_tag0,
    input  logic                                ld_tag1,
    input  logic                                ld_valid0,
    input  logic                                ld_valid1,
    input  logic                                ld_dirty0,
    input  logic                                ld_dirty1,
    input  logic                                ld_lru,
    input  logic                                valid0_in,
    input  logic                                valid1_in,
    input  logic                                dirty0_in,
    input  logic                                dirty1_in,
    input  logic                                lru_in,
    input  logic                                datain0_sel,
    input  logic                                datain1_sel,
    input  logic                                mem_addr_sel,
    input  logic [l2_cache_pkg::line_bytes-1:0] byte_enable0,
    input  logic [l2_cache_pkg::line_bytes-1:0] byte_enable1,

    output logic                                hit0,
    output logic                                hit1,
    output logic                                lru_out,
    output logic                                valid0_out,
    output logic                                valid1_out,
    output logic                                dirty0_out,
    output logic                                dirty1_out,
    output logic [l2_cache_pkg::line_bits-1:0]  mem_rdata256,
    output logic [l2_cache_pkg::addr_bits-1:0]  pmem_address,
    output logic [l2_cache_pkg::line_bits-1:0]  pmem_wdata
);
    import l2_cache_pkg::*;

    l2_addr_t             req_addr;
    l2_addr_t             phys_addr;
    logic [tag_bits-1:0]  tag0_out;
    logic [tag_bits-1:0]  tag1_out;
    logic [line_bits-1:0] line0_in;
    logic [line_bits-1:0] line1_in;
    logic [line_bits-1:0] line0_out;
    logic [line_bits-1:0] line1_out;
    logic [num_sets-1:0]  lru_bits;

    assign req_addr = l2_addr_t'(mem_address);

    // fills come from memory, write hits from the requester.
    assign line0_in = datain0_sel ? pmem_rdata : mem_wdata256;
    assign line1_in = datain1_sel ? pmem_rdata : mem_wdata256;

    l2_cache_way u_way0 (
        .clk         (clk),
        .rst         (rst),
        .set         (req_addr.fields.set),
        .ld_tag      (ld_tag0),
        .tag_in      (req_addr.fields.tag),
        .ld_valid    (ld_valid0),
        .valid_in    (valid0_in),
        .ld_dirty    (ld_dirty0),
        .dirty_in    (dirty0_in),
        .byte_enable (byte_enable0),
        .line_in     (line0_in),
        .tag_out     (tag0_out),
        .valid_out   (valid0_out),
        .dirty_out   (dirty0_out),
        .line_out    (line0_out)
    );

    l2_cache_way u_way1 (
        .clk         (clk),
        .rst         (rst),
        .set         (req_addr.fields.set),
        .ld_tag      (ld_tag1),
        .tag_in      (req_addr.fields.tag),
        .ld_valid    (ld_valid1),
        .valid_in    (valid1_in),
        .ld_dirty    (ld_dirty1),
        .dirty_in    (dirty1_in),
        .byte_enable (byte_enable1),
        .line_in     (line1_in),
        .tag_out     (tag1_out),
        .valid_out   (valid1_out),
        .dirty_out   (dirty1_out),
        .line_out    (line1_out)
    );

    assign hit0 = valid0_out && (tag0_out == req_addr.fields.tag);
    assign hit1 = valid1_out && (tag1_out == req_addr.fields.tag);

    // lru bit names the way to evict next.
    always_ff @(posedge clk) begin
        if (rst) begin
            lru_bits <= '0;
        end else if (ld_lru) begin
            lru_bits[req_addr.fields.set] <= lru_in;
        end
    end

    assign lru_out = lru_bits[req_addr.fields.set];

    // victim tag on write-back, request tag on fill.
    always_comb begin
        phys_addr = req_addr;
        if (mem_addr_sel) begin
            phys_addr.fields.tag = lru_out ? tag1_out : tag0_out;
        end
        phys_addr.fields.offset = '0;
    end

    assign pmem_address = phys_addr.raw;
    assign pmem_wdata   = lru_out ? line1_out : line0_out;
    assign mem_rdata256 = hit1 ? line1_out : line0_out;

    a_one_hit : assert property (
        @(posedge clk) disable iff (rst)
        !(hit0 && hit1)
    );

endmodule : l2_cache_datapath

// File: hdl/l2_cache_way.sv
`timescale 1ns/100ps

module l2_cache_way (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [l2_cache_pkg::set_bits-1:0]   set,

    input  logic                                ld_tag,
    input  logic [l2_cache_pkg::tag_bits-1:0]   tag_in,
    input  logic                                ld_valid,
    input  logic                                valid_in,
    input  logic                                ld_dirty,
    input  logic                                dirty_in,
    input  logic [l2_cache_pkg::line_bytes-1:0] byte_enable,
    input  logic [l2_cache_pkg::line_bits-1:0]  line_in,

    output logic [l2_cache_pkg::tag_bits-1:0]   tag_out,
    output logic                                valid_out,
    output logic                                dirty_out,
    output logic [l2_cache_pkg::line_bits-1:0]  line_out
);
    import l2_cache_pkg::*;

    logic [tag_bits-1:0]  tag_mem  [num_sets];
    logic [line_bits-1:0] data_mem [num_sets];
    logic [num_sets-1:0]  valid_bits;
    logic [num_sets-1:0]  dirty_bits;

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (ld_tag) begin
            tag_mem[set] <= tag_in;
        end
    end

    // one lane per enabled byte.
    always_ff @(posedge clk) begin
        for (int i = 0; i < line_bytes; i++) begin
            if (byte_enable[i]) begin
                data_mem[set][i*8 +: 8] <= line_in[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (ld_valid) begin
            valid_bits[set] <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dirty_bits <= '0;
        end else if (ld_dirty) begin
            dirty_bits[set] <= dirty_in;
        end
    end

    ////////////////////////////////////////////////////////////
    // asynchronous read
    ////////////////////////////////////////////////////////////

    assign tag_out   = tag_mem[set];
    assign line_out  = data_mem[set];
    assign valid_out = valid_bits[set];
    assign dirty_out = dirty_bits[set];

    // a line only turns valid together with its tag.
    a_valid_with_tag : assert property (
        @(posedge clk) disable iff (rst)
        ld_valid |-> ld_tag
    );

endmodule : l2_cache_way

// File: hdl/l2_cache_pkg.sv
package l2_cache_pkg;

    ////////////////////////////////////////////////////////////
    // address geometry
    ////////////////////////////////////////////////////////////

    localparam int addr_bits   = 32;
    localparam int offset_bits = 5;
    localparam int set_bits    = 3;
    localparam int tag_bits    = addr_bits - set_bits - offset_bits;
    localparam int num_sets    = 1 << set_bits;

    // one line is 32 bytes.
    localparam int line_bits  = 256;
    localparam int line_bytes = line_bits / 8;

    ////////////////////////////////////////////////////////////
    // address views
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [set_bits-1:0]    set;
        logic [offset_bits-1:0] offset;
    } l2_addr_fields_t;

    // the same word seen as a flat address or split into tag, set and offset.
    typedef union packed {
        logic [addr_bits-1:0] raw;
        l2_addr_fields_t      fields;
    } l2_addr_t;

endpackage : l2_cache_pkg
